// ==== pong_stim.txt ====
# commands: racket <left_y> | screen <idle> | serve <count> | frames <n> | rally <count> <n> | winner
# check <name> <ball_x> <ball_y> <left_score> <right_score> <who_won>
check reset 504 376 0 0 0
racket 361
screen 0
serve 50
frames 5
check west_serve 454 376 0 0 0
frames 35
check left_line 104 376 0 0 0
frames 2
check racket_hit 124 376 0 0 0
screen 1
screen 0
serve 25
frames 33
check top_wall 174 46 0 0 0
frames 2
check wall_bounce 154 66 0 0 0
screen 1
screen 0
racket 600
serve 50
frames 50
check glide 4 376 0 0 0
frames 1
check first_point 504 376 0 1 0
rally 50 51
rally 50 51
rally 50 51
rally 50 51
rally 50 51
rally 50 51
rally 50 51
rally 50 51
rally 50 51
check ten_points 504 376 0 10 0
winner
check match_win 504 376 0 10 1
serve 50
check scores_cleared 504 376 0 0 0

// ==== tb.f ====
pong_pkg.sv
court_geometry.sv
serve_picker.sv
flight_direction.sv
ball_motion.sv
rally_fsm.sv
score_keeper.sv
pong_ball_top.sv
tb_pong.sv

// ==== tb_pong.sv ====
// testbench for the ball and rally controller, driven by a command and expectation file
`timescale 1ns/1ps
`default_nettype none

module tb_pong
    import pong_pkg::*;
;

    logic        clk65MHz;
    logic        rst;
    logic        end_of_frame;
    logic        serve;
    logic        screen_idle;
    racket_pos_t left_racket_y;
    racket_pos_t right_racket_y;
    coord_t      ball_x;
    coord_t      ball_y;
    score_t      left_score;
    score_t      right_score;
    winner_t     who_won;

    int              fd;
    int              code;
    int              cycle_count;
    int              arg_a;
    int              arg_b;
    int              exp_x;
    int              exp_y;
    int              exp_left;
    int              exp_right;
    int              exp_winner;
    integer          seed;
    reg [8*16-1:0]   cmd;
    reg [8*24-1:0]   test_name;
    reg [8*120-1:0]  rest_of_line;

    pong_ball_top DUT (
        .clk65MHz, .rst, .end_of_frame, .serve, .screen_idle,
        .left_racket_y, .right_racket_y,
        .ball_x, .ball_y, .left_score, .right_score, .who_won
    );

    // 40 ns period
    always #20 clk65MHz = ~clk65MHz;

    // mirrors the serve counter, zero in the first cycle after reset
    always @(posedge clk65MHz) begin
        if (rst) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////

    // far racket gets a random height, it never comes into play
    task automatic set_rackets(input int left_y);
        @(posedge clk65MHz);
        left_racket_y  <= racket_pos_t'(left_y);
        right_racket_y <= racket_pos_t'($unsigned($random(seed)) % 688);
    endtask

    task automatic drive_screen_idle(input int level);
        @(posedge clk65MHz);
        screen_idle <= (level != 0);
        repeat (2) @(posedge clk65MHz);
    endtask

    // serve is sampled on the edge after it is driven, hence the +1
    task automatic serve_at(input int value);
        int i;
        bit matched;
        matched = 1'b0;
        for (i = 0; i < 256 && !matched; i++) begin
            @(posedge clk65MHz);
            if (((cycle_count + 1) % 128) == value) begin
                serve   <= 1'b1;
                matched = 1'b1;
            end
        end
        if (!matched) begin
            $display("timeout: serve counter never reached %0d", value);
            $display("Simulation finished: FAIL");
            $fatal(1, "serve wait timed out");
        end
        @(posedge clk65MHz);
        serve <= 1'b0;
        @(posedge clk65MHz);
    endtask

    task automatic give_frames(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            @(posedge clk65MHz);
            end_of_frame <= 1'b1;
            @(posedge clk65MHz);
            end_of_frame <= 1'b0;
            @(posedge clk65MHz);
        end
    endtask

    task automatic wait_for_winner;
        int i;
        bit seen;
        seen = 1'b0;
        for (i = 0; i < 20 && !seen; i++) begin
            @(posedge clk65MHz);
            seen = (who_won != 0);
        end
        if (!seen) begin
            $display("timeout: no winner was declared after the last point");
            $display("Simulation finished: FAIL");
            $fatal(1, "winner wait timed out");
        end
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic compare_field(input [8*24-1:0] name, input [8*16-1:0] field,
                                 input int expected, input int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %0s %0s expected %0d actual %0d",
                     name, field, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    // outputs are registers, sampled half a period after the edge
    task automatic check_outputs(input [8*24-1:0] name);
        @(negedge clk65MHz);
        compare_field(name, "ball_x", exp_x, ball_x);
        compare_field(name, "ball_y", exp_y, ball_y);
        compare_field(name, "left_score", exp_left, left_score);
        compare_field(name, "right_score", exp_right, right_score);
        compare_field(name, "who_won", exp_winner, who_won);
    endtask

    //////////////////////////////////////////////////
    // command loop
    //////////////////////////////////////////////////

    initial begin
        seed           = 17559;
        clk65MHz       = 1'b0;
        rst            = 1'b1;
        end_of_frame   = 1'b0;
        serve          = 1'b0;
        screen_idle    = 1'b1;
        left_racket_y  = '0;
        right_racket_y = '0;

        fd = $fopen("pong_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file pong_stim.txt");
            $display("Simulation finished: FAIL");
            $fatal(1, "missing stimulus file");
        end

        repeat (10) @(posedge clk65MHz);
        rst <= 1'b0;

        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(rest_of_line, fd);
            end else if (cmd == "racket") begin
                code = $fscanf(fd, "%d", arg_a);
                set_rackets(arg_a);
            end else if (cmd == "screen") begin
                code = $fscanf(fd, "%d", arg_a);
                drive_screen_idle(arg_a);
            end else if (cmd == "serve") begin
                code = $fscanf(fd, "%d", arg_a);
                serve_at(arg_a);
            end else if (cmd == "frames") begin
                code = $fscanf(fd, "%d", arg_a);
                give_frames(arg_a);
            end else if (cmd == "rally") begin
                code = $fscanf(fd, "%d %d", arg_a, arg_b);
                serve_at(arg_a);
                give_frames(arg_b);
            end else if (cmd == "winner") begin
                wait_for_winner();
            end else if (cmd == "check") begin
                code = $fscanf(fd, "%s %d %d %d %d %d", test_name,
                               exp_x, exp_y, exp_left, exp_right, exp_winner);
                if (code != 6) begin
                    $display("a check line in the stimulus file is incomplete");
                    $display("Simulation finished: FAIL");
                    $fatal(1, "bad stimulus line");
                end
                check_outputs(test_name);
            end else begin
                $display("unknown command %0s in the stimulus file", cmd);
                $display("Simulation finished: FAIL");
                $fatal(1, "bad stimulus command");
            end
        end

        $fclose(fd);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pong_ball_top.sv ====
// top level of the ball and rally controller
`timescale 1ns/1ps
`default_nettype none

module pong_ball_top
    import pong_pkg::*;
(
    input  logic        clk65MHz,
    input  logic        rst,
    input  logic        end_of_frame,
    input  logic        serve,
    input  logic        screen_idle,
    input  racket_pos_t left_racket_y,
    input  racket_pos_t right_racket_y,
    output coord_t      ball_x,
    output coord_t      ball_y,
    output score_t      left_score,
    output score_t      right_score,
    output winner_t     who_won
);

    game_state_t state;
    dir_t        dir;
    dir_t        serve_dir;
    zone_t       contact_zone;
    logic        at_left_line;
    logic        at_right_line;
    logic        at_top_wall;
    logic        at_bottom_wall;
    logic        edge_reached;
    logic        game_over;

    court_geometry u_court_geometry (
        .ball_x, .ball_y, .left_racket_y, .right_racket_y, .dir,
        .at_left_line, .at_right_line, .at_top_wall, .at_bottom_wall, .contact_zone
    );

    serve_picker u_serve_picker (.clk65MHz, .rst, .serve_dir);

    flight_direction u_flight_direction (
        .clk65MHz, .rst, .state, .serve_dir,
        .at_left_line, .at_right_line, .at_top_wall, .at_bottom_wall,
        .contact_zone, .dir
    );

    ball_motion u_ball_motion (
        .clk65MHz, .rst, .end_of_frame, .state, .dir,
        .ball_x, .ball_y, .edge_reached
    );

    rally_fsm u_rally_fsm (
        .clk65MHz, .rst, .serve, .screen_idle, .at_left_line, .at_right_line,
        .contact_zone, .dir, .edge_reached, .game_over, .state
    );

    score_keeper u_score_keeper (
        .clk65MHz, .rst, .state, .dir, .edge_reached,
        .left_score, .right_score, .game_over, .who_won
    );

endmodule

`default_nettype wire

// ==== score_keeper.sv ====
// player score registers, game over flag and winner register
`timescale 1ns/1ps
`default_nettype none

module score_keeper
    import pong_pkg::*;
(
    input  logic        clk65MHz,
    input  logic        rst,
    input  game_state_t state,
    input  dir_t        dir,
    input  logic        edge_reached,
    output score_t      left_score,
    output score_t      right_score,
    output logic        game_over,
    output winner_t     who_won
);

    logic heads_west;

    // ball leaving on the left scores for player 1
    assign heads_west = (dir == DIR_W) || (dir == DIR_NW) || (dir == DIR_SW);

    always_ff @(posedge clk65MHz) begin
        if (rst || state == ST_IDLE) begin
            left_score  <= '0;
            right_score <= '0;
            game_over   <= 1'b0;
            who_won     <= '0;
        end else begin
            if (edge_reached) begin
                if (heads_west) begin
                    right_score <= right_score + 1'b1;
                end else begin
                    left_score <= left_score + 1'b1;
                end
            end

            // one clock behind the score update
            game_over <= (left_score == POINTS_TO_WIN) || (right_score == POINTS_TO_WIN);

            if (state == ST_WIN) begin
                who_won <= (right_score > left_score) ? winner_t'(1) : winner_t'(2);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rally_fsm.sv ====
// game state register and next-state logic
`timescale 1ns/1ps
`default_nettype none

module rally_fsm
    import pong_pkg::*;
(
    input  logic        clk65MHz,
    input  logic        rst,
    input  logic        serve,
    input  logic        screen_idle,
    input  logic        at_left_line,
    input  logic        at_right_line,
    input  zone_t       contact_zone,
    input  dir_t        dir,
    input  logic        edge_reached,
    input  logic        game_over,
    output game_state_t state
);

    game_state_t state_nxt;
    logic        heads_east;
    logic        heads_west;
    logic        missed;

    assign heads_east = (dir == DIR_E) || (dir == DIR_NE) || (dir == DIR_SE);
    assign heads_west = (dir == DIR_W) || (dir == DIR_NW) || (dir == DIR_SW);

    // zone refers to the racket on the heading side
    assign missed = (contact_zone == ZONE_MISS) &&
                    ((at_left_line && heads_west) || (at_right_line && heads_east));

    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        if (screen_idle) begin
            state_nxt = ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: state_nxt = ST_START;
                ST_START: begin
                    if (game_over) begin
                        state_nxt = ST_WIN;
                    end else if (serve) begin
                        state_nxt = ST_FLY;
                    end
                end
                ST_FLY: begin
                    if (missed) begin
                        state_nxt = ST_SCORED;
                    end
                end
                ST_SCORED: begin
                    if (edge_reached) begin
                        state_nxt = ST_START;
                    end
                end
                ST_WIN: begin
                    if (serve) begin
                        state_nxt = ST_IDLE;
                    end
                end
                default: state_nxt = ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== ball_motion.sv ====
// ball position registers, per-frame stepping and glide stop detection
`timescale 1ns/1ps
`default_nettype none

module ball_motion
    import pong_pkg::*;
(
    input  logic        clk65MHz,
    input  logic        rst,
    input  logic        end_of_frame,
    input  game_state_t state,
    input  dir_t        dir,
    output coord_t      ball_x,
    output coord_t      ball_y,
    output logic        edge_reached
);

    coord_t step_x;
    coord_t step_y;
    logic   past_edge;

    // two's complement steps, west and north are negative
    always_comb begin
        case (dir)
            DIR_W:   begin step_x = -coord_t'(BALL_SPEED); step_y = '0; end
            DIR_NW:  begin step_x = -coord_t'(BALL_SPEED); step_y = -coord_t'(BALL_SPEED); end
            DIR_SW:  begin step_x = -coord_t'(BALL_SPEED); step_y = coord_t'(BALL_SPEED); end
            DIR_E:   begin step_x = coord_t'(BALL_SPEED); step_y = '0; end
            DIR_NE:  begin step_x = coord_t'(BALL_SPEED); step_y = -coord_t'(BALL_SPEED); end
            DIR_SE:  begin step_x = coord_t'(BALL_SPEED); step_y = coord_t'(BALL_SPEED); end
            default: begin step_x = '0; step_y = '0; end
        endcase
    end

    assign past_edge    = (ball_x > RIGHT_EDGE_X) || (ball_x < LEFT_EDGE_X);
    assign edge_reached = (state == ST_SCORED) && end_of_frame && past_edge;

    //////////////////////////////////////////////////
    // position registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            ball_x <= coord_t'(CENTER_X);
            ball_y <= coord_t'(CENTER_Y);
        end else begin
            case (state)
                ST_IDLE, ST_START: begin
                    ball_x <= coord_t'(CENTER_X);
                    ball_y <= coord_t'(CENTER_Y);
                end
                ST_FLY, ST_SCORED: begin
                    // glide stops once outside the court edge
                    if (end_of_frame && !edge_reached) begin
                        ball_x <= ball_x + step_x;
                        ball_y <= ball_y + step_y;
                    end
                end
                default: begin
                    ball_x <= ball_x;
                    ball_y <= ball_y;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== flight_direction.sv ====
// flight direction register with serve load, wall mirror and racket hit
`timescale 1ns/1ps
`default_nettype none

module flight_direction
    import pong_pkg::*;
(
    input  logic        clk65MHz,
    input  logic        rst,
    input  game_state_t state,
    input  dir_t        serve_dir,
    input  logic        at_left_line,
    input  logic        at_right_line,
    input  logic        at_top_wall,
    input  logic        at_bottom_wall,
    input  zone_t       contact_zone,
    output dir_t        dir
);

    dir_t dir_nxt;
    logic heads_east;
    logic heads_west;
    logic between_lines;
    logic hit_right;
    logic hit_left;

    assign heads_east    = (dir == DIR_E) || (dir == DIR_NE) || (dir == DIR_SE);
    assign heads_west    = (dir == DIR_W) || (dir == DIR_NW) || (dir == DIR_SW);
    assign between_lines = !at_left_line && !at_right_line;
    assign hit_right     = at_right_line && heads_east && (contact_zone != ZONE_MISS);
    assign hit_left      = at_left_line && heads_west && (contact_zone != ZONE_MISS);

    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            dir <= DIR_NONE;
        end else begin
            dir <= dir_nxt;
        end
    end

    //////////////////////////////////////////////////
    // next direction
    //////////////////////////////////////////////////

    always_comb begin
        dir_nxt = dir;
        case (state)
            ST_IDLE:  dir_nxt = DIR_NONE;
            ST_START: dir_nxt = serve_dir;
            ST_FLY, ST_SCORED: begin
                if (between_lines && at_top_wall && dir == DIR_NE) begin
                    dir_nxt = DIR_SE;
                end else if (between_lines && at_top_wall && dir == DIR_NW) begin
                    dir_nxt = DIR_SW;
                end else if (between_lines && at_bottom_wall && dir == DIR_SE) begin
                    dir_nxt = DIR_NE;
                end else if (between_lines && at_bottom_wall && dir == DIR_SW) begin
                    dir_nxt = DIR_NW;
                end else if (state == ST_FLY && hit_right) begin
                    // top sends the ball up, bottom sends it down
                    case (contact_zone)
                        ZONE_TOP: dir_nxt = DIR_NW;
                        ZONE_MID: dir_nxt = DIR_W;
                        default:  dir_nxt = DIR_SW;
                    endcase
                end else if (state == ST_FLY && hit_left) begin
                    case (contact_zone)
                        ZONE_TOP: dir_nxt = DIR_NE;
                        ZONE_MID: dir_nxt = DIR_E;
                        default:  dir_nxt = DIR_SE;
                    endcase
                end
            end
            default: dir_nxt = dir;
        endcase
    end

endmodule

`default_nettype wire

// ==== serve_picker.sv ====
// free-running serve counter and its mapping to a serve direction
`timescale 1ns/1ps
`default_nettype none

module serve_picker
    import pong_pkg::*;
(
    input  logic clk65MHz,
    input  logic rst,
    output dir_t serve_dir
);

    serve_count_t count;

    // wraps at 128
    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // west half first, then east half
    always_comb begin
        if (count <= SERVE_SW_MAX) begin
            serve_dir = DIR_SW;
        end else if (count <= SERVE_NW_MAX) begin
            serve_dir = DIR_NW;
        end else if (count <= SERVE_W_MAX) begin
            serve_dir = DIR_W;
        end else if (count <= SERVE_E_MAX) begin
            serve_dir = DIR_E;
        end else if (count <= SERVE_NE_MAX) begin
            serve_dir = DIR_NE;
        end else begin
            serve_dir = DIR_SE;
        end
    end

endmodule

`default_nettype wire

// ==== court_geometry.sv ====
// wall and racket line detection with racket contact zone classification
`timescale 1ns/1ps
`default_nettype none

module court_geometry
    import pong_pkg::*;
(
    input  coord_t      ball_x,
    input  coord_t      ball_y,
    input  racket_pos_t left_racket_y,
    input  racket_pos_t right_racket_y,
    input  dir_t        dir,
    output logic        at_left_line,
    output logic        at_right_line,
    output logic        at_top_wall,
    output logic        at_bottom_wall,
    output zone_t       contact_zone
);

    logic        heads_east;
    racket_pos_t racket_y;
    logic [11:0] ball_top;
    logic [11:0] ball_bottom;
    logic [11:0] racket_top;
    logic [11:0] racket_end;
    logic [11:0] offset;

    assign at_left_line   = (ball_x <= LEFT_RACKET_X);
    assign at_right_line  = (ball_x >= RIGHT_RACKET_X);
    assign at_top_wall    = (ball_y <= TOP_WALL_Y);
    assign at_bottom_wall = (ball_y >= BOTTOM_WALL_Y);

    //////////////////////////////////////////////////
    // racket contact zone
    //////////////////////////////////////////////////

    // the racket on the side the ball is heading to
    assign heads_east = (dir == DIR_E) || (dir == DIR_NE) || (dir == DIR_SE);
    assign racket_y   = heads_east ? right_racket_y : left_racket_y;

    // 12 bits so the sums cannot wrap
    assign ball_top    = 12'(ball_y);
    assign ball_bottom = ball_top + 12'(BALL_SIZE);
    assign racket_top  = 12'(racket_y);
    assign racket_end  = racket_top + 12'(RACKET_HEIGHT);
    assign offset      = ball_bottom - racket_top;

    always_comb begin
        if (ball_bottom < racket_top || ball_top > racket_end) begin
            contact_zone = ZONE_MISS;
        end else if (offset < 12'(ZONE_TOP_END)) begin
            contact_zone = ZONE_TOP;
        end else if (offset < 12'(ZONE_MID_END)) begin
            contact_zone = ZONE_MID;
        end else begin
            contact_zone = ZONE_BOTTOM;
        end
    end

endmodule

`default_nettype wire

// ==== pong_pkg.sv ====
// court geometry, speed and score constants, vector types and game enums
`default_nettype none

package pong_pkg;

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////

    // ball coordinate in pixels
    typedef logic [10:0] coord_t;
    // top edge of a racket
    typedef logic [9:0]  racket_pos_t;
    typedef logic [3:0]  score_t;
    // 0 none, 1 player 1 (right), 2 player 2 (left)
    typedef logic [1:0]  winner_t;
    typedef logic [6:0]  serve_count_t;

    //////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_W,
        DIR_NW,
        DIR_SW,
        DIR_E,
        DIR_NE,
        DIR_SE
    } dir_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_FLY,
        ST_SCORED,
        ST_WIN
    } game_state_t;

    typedef enum logic [1:0] {
        ZONE_TOP,
        ZONE_MID,
        ZONE_BOTTOM,
        ZONE_MISS
    } zone_t;

    //////////////////////////////////////////////////
    // court and ball constants
    //////////////////////////////////////////////////

    localparam int BALL_SIZE      = 15;
    localparam int RACKET_HEIGHT  = 80;
    localparam int LEFT_RACKET_X  = 104;
    localparam int RIGHT_RACKET_X = 898;
    localparam int TOP_WALL_Y     = 51;
    localparam int BOTTOM_WALL_Y  = 702;
    localparam int BALL_SPEED     = 10;
    localparam int LEFT_EDGE_X    = 11;
    localparam int RIGHT_EDGE_X   = 1012;
    localparam int CENTER_X       = 504;
    localparam int CENTER_Y       = 376;
    localparam int POINTS_TO_WIN  = 10;

    // ball bottom offsets below the racket top
    localparam int ZONE_TOP_END   = 26;
    localparam int ZONE_MID_END   = 55;

    // serve bands, upper bounds of the counter value
    localparam int SERVE_SW_MAX   = 19;
    localparam int SERVE_NW_MAX   = 38;
    localparam int SERVE_W_MAX    = 64;
    localparam int SERVE_E_MAX    = 89;
    localparam int SERVE_NE_MAX   = 108;

endpackage

`default_nettype wire
